// ==== golden_vid_rd.txt ====
# W <half 0=left 1=right> <word addr hex> <32-bit word hex>
# P <line> <screen x hex> <expected 24-bit pixel hex>
W 0 0 D1A040D0
W 0 1 42D2A041
W 0 2 A043D3A0
W 0 3 D5A044D4
W 0 4 46D6A045
W 0 5 A047D7A0
W 0 6 E1A140E0
W 0 7 42E2A141
W 0 8 A143E3A1
W 0 9 E5A144E4
W 0 A 46E6A145
W 0 B A147E7A1
W 1 0 D1B040D0
W 1 1 42D2B041
W 1 2 B043D3B0
W 1 3 D5B044D4
W 1 4 46D6B045
W 1 5 B047D7B0
W 1 6 E1B140E0
W 1 7 42E2B141
W 1 8 B143E3B1
W 1 9 E5B144E4
W 1 A 46E6B145
W 1 B B147E7B1
P 0 0 A040D0
P 0 1 A041D1
P 0 2 A042D2
P 0 3 A043D3
P 0 4 A044D4
P 0 5 A045D5
P 0 6 A046D6
P 0 7 A047D7
P 0 8 B040D0
P 0 9 B041D1
P 0 A B042D2
P 0 B B043D3
P 0 C B044D4
P 0 D B045D5
P 0 E B046D6
P 0 F B047D7
P 1 0 A140E0
P 1 1 A141E1
P 1 2 A142E2
P 1 3 A143E3
P 1 4 A144E4
P 1 5 A145E5
P 1 6 A146E6
P 1 7 A147E7
P 1 8 B140E0
P 1 9 B141E1
P 1 A B142E2
P 1 B B143E3
P 1 C B144E4
P 1 D B145E5
P 1 E B146E6
P 1 F B147E7

// ==== vlog.f ====
+incdir+.
vid_rd_pkg.sv
line_timing.sv
line_reader.sv
pixel_merge.sv
vid_rd_buf.sv
tb_vid_rd_buf.sv

// ==== Bender.yml ====
package:
  name: vid_rd_buf

sources:
  - include_dirs:
      - .
    files:
      - vid_rd_pkg.sv
      - line_timing.sv
      - line_reader.sv
      - pixel_merge.sv
      - vid_rd_buf.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_vid_rd_buf.sv

// ==== tb_vid_rd_buf.sv ====
`timescale 1ns/1ns
`include "vid_rd_defs.svh"

module tb_vid_rd_buf
    import vid_rd_pkg::*;
();

    localparam int DE_TIMEOUT = 8;              // cycles allowed for vout_de to rise

    logic       vout_clk;
    logic       rst_n;
    logic       rd_fsync;
    logic       rd_en;
    load_word_t load;
    logic       vout_de;
    pix_t       vout_data;

    word_t  gold_word [0:1][0:`VID_BUF_DEPTH-1];                  // [half][addr]
    pix_t   gold_pix  [0:`VID_V_ACTIVE-1][0:`VID_H_ACTIVE-1];     // [line][x]
    bit     gold_ok;
    integer seed;                               // gap lengths
    int     en_cnt;                             // rd_en cycles still to drive
    int     lines_run;
    int     timing_errs;                        // de timing and blanking
    int     total_errs;
    int     tests_run;
    int     tests_failed;
    int     errs;
    int     errs_l;
    int     errs_r;
    int     errs_f;

    vid_rd_buf vid_rd_buf_inst (
        .vout_clk  (vout_clk),
        .rst_n     (rst_n),
        .rd_fsync  (rd_fsync),
        .rd_en     (rd_en),
        .load      (load),
        .vout_de   (vout_de),
        .vout_data (vout_data)
    );

    initial
    begin
        vout_clk = 1'b0;
        forever #20 vout_clk = ~vout_clk;       // 40 ns period
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////
    // falling edge, rd_en follows en_cnt
    task automatic step_cycle();
        begin
            @(negedge vout_clk);
            if (en_cnt > 0)
            begin
                rd_en  = 1'b1;
                en_cnt = en_cnt - 1;
            end
            else
                rd_en = 1'b0;
        end
    endtask

    task automatic check_idle(inout int n_err);
        begin
            if (vout_de !== 1'b0)
            begin
                $display("[ERROR] %0t ns: vout_de idle, expected 0 got %b", $time, vout_de);
                n_err++;
            end
            if (vout_data !== '0)
            begin
                $display("[ERROR] %0t ns: vout_data idle, expected 0 got %h", $time, vout_data);
                n_err++;
            end
        end
    endtask

    task automatic read_golden(output bit ok);
        int               fd;
        int               c;
        int               r;
        int               n_w;
        int               n_p;
        logic [31:0]      f1;
        logic [31:0]      f2;
        logic [31:0]      f3;
        logic [8*128-1:0] rest;                 // legend text, dropped
        begin
            ok  = 1'b0;
            n_w = 0;
            n_p = 0;
            fd  = $fopen("golden_vid_rd.txt", "r");
            if (fd == 0)
                $display("could not open golden_vid_rd.txt");
            else
            begin
                c = $fgetc(fd);
                while (c != -1)
                begin
                    if (c == "#")
                        r = $fgets(rest, fd);
                    else if (c == "W")
                    begin
                        r = $fscanf(fd, "%h %h %h", f1, f2, f3); // half addr word
                        if (r == 3 && f1 < 2 && f2 < `VID_BUF_DEPTH)
                        begin
                            gold_word[f1][f2] = f3;
                            n_w++;
                        end
                    end
                    else if (c == "P")
                    begin
                        r = $fscanf(fd, "%h %h %h", f1, f2, f3); // line x pixel
                        if (r == 3 && f1 < `VID_V_ACTIVE && f2 < `VID_H_ACTIVE)
                        begin
                            gold_pix[f1][f2] = f3[`VID_PIX_W-1:0];
                            n_p++;
                        end
                    end
                    c = $fgetc(fd);
                end
                $fclose(fd);
                ok = (n_w == 2 * `VID_BUF_DEPTH) && (n_p == `VID_V_ACTIVE * `VID_H_ACTIVE);
                if (!ok)
                    $display("golden file gave %0d words and %0d pixels, too few", n_w, n_p);
            end
        end
    endtask

    task automatic write_buffers(inout int n_err);
        int i;
        begin
            for (i = 0; i < 2 * `VID_BUF_DEPTH; i++)
            begin
                step_cycle();
                load.wr_en = 1'b1;
                load.half  = (i >= `VID_BUF_DEPTH) ? HALF_RIGHT : HALF_LEFT;
                load.addr  = `VID_ADDR_W'(i % `VID_BUF_DEPTH);
                load.data  = gold_word[i / `VID_BUF_DEPTH][i % `VID_BUF_DEPTH];
                check_idle(n_err);
            end
            step_cycle();
            load = '0;
            check_idle(n_err);
        end
    endtask

    // one active line against golden line exp_line, then a random gap
    task automatic scan_line(input int exp_line, output int n_l, output int n_r);
        int lat;
        int k;
        int gap;
        begin
            n_l    = 0;
            n_r    = 0;
            lat    = 0;
            en_cnt = `VID_H_ACTIVE;
            step_cycle();                       // rd_en rises here
            while (!vout_de && lat < DE_TIMEOUT)
            begin
                check_idle(timing_errs);
                step_cycle();
                lat++;
            end
            if (!vout_de)
            begin
                $display("timeout, vout_de never rose on screen line %0d", lines_run);
                timing_errs++;
                n_l++;
                n_r++;
            end
            else
            begin
                if (lat != 2)
                begin
                    $display("[ERROR] %0t ns: de latency expected 2 got %0d", $time, lat);
                    timing_errs++;
                end
                for (k = 0; k < `VID_H_ACTIVE; k++)
                begin
                    if (vout_de !== 1'b1)
                    begin
                        $display("[ERROR] %0t ns: vout_de low at pixel %0d", $time, k);
                        timing_errs++;
                    end
                    if (vout_data !== gold_pix[exp_line][k])
                    begin
                        $display("[ERROR] %0t ns: line %0d pixel %0d expected %h got %h",
                                 $time, lines_run, k, gold_pix[exp_line][k], vout_data);
                        if (k < `VID_H_HALF)
                            n_l++;
                        else
                            n_r++;
                    end
                    step_cycle();
                end
            end
            gap = 2 + ({$random(seed)} % 6);    // de must stay low right after x=15
            for (k = 0; k < gap; k++)
            begin
                check_idle(timing_errs);
                step_cycle();
            end
            lines_run++;
        end
    endtask

    task automatic pulse_fsync();
        int i;
        begin
            for (i = 0; i < 4; i++)
            begin
                step_cycle();
                rd_fsync = (i < 2);             // two cycles high
                check_idle(timing_errs);
            end
        end
    endtask

    task automatic report_test(input string name, input int n_err);
        begin
            tests_run++;
            total_errs += n_err;
            if (n_err == 0)
                $display("test %-24s passed", name);
            else
            begin
                $display("test %-24s failed, %0d errors", name, n_err);
                tests_failed++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////
    initial
    begin
        rst_n        = 1'b0;
        rd_fsync     = 1'b0;
        rd_en        = 1'b0;
        load         = '0;
        seed         = 87;
        en_cnt       = 0;
        lines_run    = 0;
        timing_errs  = 0;
        total_errs   = 0;
        tests_run    = 0;
        tests_failed = 0;
        errs         = 0;
        read_golden(gold_ok);

        repeat (8)
        begin
            step_cycle();
            check_idle(errs);                   // outputs held in reset
        end
        rst_n = 1'b1;
        write_buffers(errs);                    // still blank while loading
        report_test("reset and idle", errs);

        if (gold_ok)
        begin
            scan_line(0, errs_l, errs_r);
            report_test("line 0 left half", errs_l);
            report_test("line 0 right half", errs_r);
            scan_line(1, errs_l, errs_r);
            report_test("line 1 both halves", errs_l + errs_r);
            pulse_fsync();                      // line counter back to 0
            scan_line(0, errs_l, errs_r);
            errs_f = errs_l + errs_r;
            scan_line(1, errs_l, errs_r);
            report_test("frame sync restart", errs_f + errs_l + errs_r);
            report_test("de timing and blanking", timing_errs);
        end
        else
        begin
            $display("golden data not usable, line tests skipped");
            tests_failed++;
        end

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, total_errs);
        if (tests_failed == 0 && total_errs == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

// ==== vid_rd_buf.sv ====
`timescale 1ns/1ns

module vid_rd_buf
    import vid_rd_pkg::*;
(
    input  logic       vout_clk,
    input  logic       rst_n,
    input  logic       rd_fsync,
    input  logic       rd_en,
    input  load_word_t load,                    // buffer write from memory side
    output logic       vout_de,
    output pix_t       vout_data
);

    scan_t      scan;
    logic       left_en;
    logic       right_en;
    load_word_t left_load;
    load_word_t right_load;
    pix_t       left_pix;
    pix_t       right_pix;

    // steer write strobe by half, rest of the request is shared
    always_comb
    begin
        left_load        = load;
        left_load.wr_en  = load.wr_en & (load.half == HALF_LEFT);
        right_load       = load;
        right_load.wr_en = load.wr_en & (load.half == HALF_RIGHT);
    end

    line_timing u_line_timing (
        .vout_clk (vout_clk),
        .rst_n    (rst_n),
        .rd_fsync (rd_fsync),
        .rd_en    (rd_en),
        .scan     (scan),
        .left_en  (left_en),
        .right_en (right_en)
    );

    line_reader u_left_reader (                 // pixels 0..7 of each line
        .vout_clk (vout_clk),
        .rst_n    (rst_n),
        .load     (left_load),
        .line     (scan.line),
        .part_en  (left_en),
        .pix      (left_pix)
    );

    line_reader u_right_reader (                // pixels 8..15 of each line
        .vout_clk (vout_clk),
        .rst_n    (rst_n),
        .load     (right_load),
        .line     (scan.line),
        .part_en  (right_en),
        .pix      (right_pix)
    );

    pixel_merge u_pixel_merge (
        .vout_clk  (vout_clk),
        .rst_n     (rst_n),
        .scan      (scan),
        .left_pix  (left_pix),
        .right_pix (right_pix),
        .vout_de   (vout_de),
        .vout_data (vout_data)
    );

endmodule

// ==== pixel_merge.sv ====
`timescale 1ns/1ns

module pixel_merge
    import vid_rd_pkg::*;
(
    input  logic  vout_clk,
    input  logic  rst_n,
    input  scan_t scan,                         // scan state in the reader input cycle
    input  pix_t  left_pix,
    input  pix_t  right_pix,
    output logic  vout_de,
    output pix_t  vout_data
);

    logic de_d;                                 // de aligned to reader output
    logic right_d;                              // half select at the same alignment
    pix_t sel_pix;

    ////////////////////////////////////////////////////////////
    // align scan state with reader latency
    ////////////////////////////////////////////////////////////
    always_ff @(posedge vout_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            de_d    <= 1'b0;
            right_d <= 1'b0;
        end
        else
        begin
            de_d    <= scan.de;
            right_d <= scan.right_half;
        end
    end

    assign sel_pix = right_d ? right_pix : left_pix;

    ////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge vout_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            vout_de   <= 1'b0;
            vout_data <= '0;
        end
        else
        begin
            vout_de   <= de_d;                  // rd_en plus two
            vout_data <= de_d ? sel_pix : '0;   // black in blanking
        end
    end

    // both readers idle outside the active line
    a_blank_zero: assert property (@(posedge vout_clk) disable iff (!rst_n)
        !de_d |-> sel_pix == '0)
        else $error("reader pixel %h outside active line", sel_pix);

endmodule

// ==== line_reader.sv ====
`timescale 1ns/1ns
`include "vid_rd_defs.svh"

module line_reader
    import vid_rd_pkg::*;
(
    input  logic                  vout_clk,
    input  logic                  rst_n,
    input  load_word_t            load,     // write port, already steered
    input  logic [`VID_POS_W-1:0] line,     // current line
    input  logic                  part_en,  // this half is on screen
    output pix_t                  pix       // unpacked pixel, zero when idle
);

    localparam int ADDR_W = `VID_ADDR_W;

    word_t             mem [0:`VID_BUF_DEPTH-1]; // half-line words, all lines
    logic [ADDR_W-1:0] base_addr;               // first word of the line
    logic [ADDR_W-1:0] rd_addr;
    logic [2:0]        word_idx;                // word offset within the half
    logic [1:0]        phase;                   // pixel slot in a 3-word group
    word_t             cur_word;                // window, newest word
    word_t             prev_word;               // window, older word
    pix_t              next_pix;

    ////////////////////////////////////////////////////////////
    // word buffer
    ////////////////////////////////////////////////////////////
    always_ff @(posedge vout_clk)
    begin
        if (load.wr_en)
            mem[load.addr] <= load.data;
    end

    assign base_addr = ADDR_W'(line * `VID_WORDS_HALF);
    assign rd_addr   = base_addr + ADDR_W'(word_idx);
    assign cur_word  = mem[rd_addr];            // async read, word 0 ready at line start

    ////////////////////////////////////////////////////////////
    // fetch pointer and phase
    ////////////////////////////////////////////////////////////
    always_ff @(posedge vout_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            word_idx <= '0;
            phase    <= '0;
        end
        else if (!part_en)
        begin
            word_idx <= '0;                     // park on line base while idle
            phase    <= '0;
        end
        else
        begin
            phase <= phase + 2'd1;
            if (phase != 2'd3)
                word_idx <= word_idx + 3'd1;    // 4th pixel needs no new word
        end
    end

    // older half of the window
    always_ff @(posedge vout_clk)
    begin
        if (part_en && phase != 2'd3)
            prev_word <= cur_word;
    end

    ////////////////////////////////////////////////////////////
    // 24-in-32 unpack
    ////////////////////////////////////////////////////////////
    always_comb
    begin
        case (phase)
            2'd0:    next_pix = cur_word[23:0];                      // low 3 bytes
            2'd1:    next_pix = {cur_word[15:0], prev_word[31:24]};  // straddles w0/w1
            2'd2:    next_pix = {cur_word[7:0], prev_word[31:16]};   // straddles w1/w2
            default: next_pix = prev_word[31:8];                     // top 3 bytes of w2
        endcase
    end

    always_ff @(posedge vout_clk or negedge rst_n)
    begin
        if (!rst_n)
            pix <= '0;
        else if (part_en)
            pix <= next_pix;
        else
            pix <= '0;                          // blank outside this half
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////
    a_wr_addr: assert property (@(posedge vout_clk) disable iff (!rst_n)
        load.wr_en |-> load.addr < `VID_BUF_DEPTH)
        else $error("write address %0d beyond buffer", load.addr);

    // timing stage must not scan more lines than are buffered
    a_line_range: assert property (@(posedge vout_clk) disable iff (!rst_n)
        part_en |-> line < `VID_V_ACTIVE)
        else $error("line %0d not buffered", line);

endmodule

// ==== line_timing.sv ====
`timescale 1ns/1ns
`include "vid_rd_defs.svh"

module line_timing
    import vid_rd_pkg::*;
(
    input  logic  vout_clk,
    input  logic  rst_n,
    input  logic  rd_fsync,                     // frame sync level
    input  logic  rd_en,                        // line active level
    output scan_t scan,
    output logic  left_en,                      // read strobe, left half
    output logic  right_en                      // read strobe, right half
);

    logic [`VID_POS_W-1:0] pos_cnt;             // x position in line
    logic [`VID_POS_W-1:0] line_cnt;            // y position in frame
    logic                  rd_en_d;
    logic                  rd_fsync_d;
    logic                  in_right;
    logic                  line_end;
    logic                  frame_start;

    ////////////////////////////////////////////////////////////
    // edge detect
    ////////////////////////////////////////////////////////////
    always_ff @(posedge vout_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            rd_en_d    <= 1'b0;
            rd_fsync_d <= 1'b0;
        end
        else
        begin
            rd_en_d    <= rd_en;
            rd_fsync_d <= rd_fsync;
        end
    end

    assign line_end    = rd_en_d & ~rd_en;      // falling rd_en
    assign frame_start = rd_fsync & ~rd_fsync_d; // rising fsync

    ////////////////////////////////////////////////////////////
    // position and line counters
    ////////////////////////////////////////////////////////////
    always_ff @(posedge vout_clk or negedge rst_n)
    begin
        if (!rst_n)
            pos_cnt <= '0;
        else if (rd_en)
            pos_cnt <= pos_cnt + 1'b1;
        else
            pos_cnt <= '0;                      // restart in blanking
    end

    always_ff @(posedge vout_clk or negedge rst_n)
    begin
        if (!rst_n)
            line_cnt <= '0;
        else if (frame_start)
            line_cnt <= '0;                     // new frame wins over line end
        else if (line_end)
            line_cnt <= line_cnt + 1'b1;
    end

    // half split from the registered position
    assign in_right = (pos_cnt >= `VID_H_HALF);
    assign left_en  = rd_en & ~in_right;
    assign right_en = rd_en & in_right;

    always_comb
    begin
        scan.de         = rd_en;
        scan.right_half = in_right;
        scan.line       = line_cnt;
    end

    // rd_en must drop after one active line
    a_pos_in_line: assert property (@(posedge vout_clk) disable iff (!rst_n)
        rd_en |-> pos_cnt <= `VID_H_ACTIVE)
        else $error("position %0d past active line", pos_cnt);

endmodule

// ==== vid_rd_pkg.sv ====
`include "vid_rd_defs.svh"

package vid_rd_pkg;

    typedef logic [`VID_PIX_W-1:0]  pix_t;      // one screen pixel
    typedef logic [`VID_WORD_W-1:0] word_t;     // one packed buffer word

    localparam logic HALF_LEFT  = 1'b0;         // load goes to left reader
    localparam logic HALF_RIGHT = 1'b1;         // load goes to right reader

    ////////////////////////////////////////////////////////////
    // buffer write request, memory side stand-in
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                   wr_en;          // write strobe
        logic                   half;           // 0 left, 1 right
        logic [`VID_ADDR_W-1:0] addr;           // word address
        word_t                  data;           // packed pixel word
    } load_word_t;

    ////////////////////////////////////////////////////////////
    // scan state from the timing stage
    ////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                  de;              // copy of rd_en
        logic                  right_half;      // x in right half
        logic [`VID_POS_W-1:0] line;            // line counter
    } scan_t;

endpackage

// ==== vid_rd_defs.svh ====
`ifndef VID_RD_DEFS_SVH
`define VID_RD_DEFS_SVH

////////////////////////////////////////////////////////////
// screen geometry
////////////////////////////////////////////////////////////

`define VID_H_ACTIVE    16                      // active pixels per line
`define VID_H_HALF      8                       // pixels per screen half
`define VID_V_ACTIVE    2                       // lines held per frame

////////////////////////////////////////////////////////////
// data widths
////////////////////////////////////////////////////////////

`define VID_PIX_W       24                      // rgb888 pixel
`define VID_WORD_W      32                      // buffer word, four pixels in three words

////////////////////////////////////////////////////////////
// buffer sizing
////////////////////////////////////////////////////////////

`define VID_WORDS_HALF  6                       // words per half line
`define VID_BUF_DEPTH   (`VID_WORDS_HALF * `VID_V_ACTIVE) // words per reader
`define VID_ADDR_W      4                       // word address bits
`define VID_POS_W       13                      // x and y counter bits

`endif
